//--- verilog/tx_frontend_pkg.sv
`default_nettype none

package tx_frontend_pkg;

  // Widths and binary points of the sample formats
  localparam int SAMPLE_W    = 16;
  localparam int SAMPLE_FRAC = 15;
  localparam int WIDE_W      = 24;
  localparam int WIDE_FRAC   = 23;
  localparam int COEF_W      = 18;
  localparam int COEF_FRAC   = 17;

  // Settings bus and crossbar control
  localparam int SET_ADDR_W = 8;
  localparam int SET_DATA_W = 32;
  localparam int MUX_W      = 8;
  localparam int MUX_SEL_W  = 4;

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [WIDE_W-1:0]   wide_t;
  typedef logic signed [COEF_W-1:0]   coef_t;
  typedef logic [MUX_W-1:0]           mux_ctrl_t;
  typedef logic [SET_ADDR_W-1:0]      set_addr_t;
  typedef logic [SET_DATA_W-1:0]      set_data_t;

  // Register map
  localparam set_addr_t SR_OFFSET_I   = 8'd0;
  localparam set_addr_t SR_OFFSET_Q   = 8'd1;
  localparam set_addr_t SR_MAG_CORR   = 8'd2;
  localparam set_addr_t SR_PHASE_CORR = 8'd3;
  localparam set_addr_t SR_MUX        = 8'd4;

  // I to DAC I, Q to DAC Q
  localparam mux_ctrl_t MUX_RESET = 8'h10;

  // Nibble codes of the crossbar, anything else gives zero
  localparam logic [MUX_SEL_W-1:0] XBAR_SEL_I = 4'd0;
  localparam logic [MUX_SEL_W-1:0] XBAR_SEL_Q = 4'd1;

  // Low bits dropped by the rounder
  localparam int ROUND_BITS = WIDE_W - SAMPLE_W;

  // Saturation limits of the wide format
  localparam wide_t WIDE_MAX = {1'b0, {(WIDE_W-1){1'b1}}};
  localparam wide_t WIDE_MIN = {1'b1, {(WIDE_W-1){1'b0}}};

endpackage

`default_nettype wire

//--- verilog/setting_reg.sv
`default_nettype none

module setting_reg
  import tx_frontend_pkg::*;
#(
  parameter set_addr_t        my_addr  = SR_OFFSET_I,
  parameter int               width    = SET_DATA_W,
  parameter logic [width-1:0] at_reset = '0
) (
  input  wire              clk,
  input  wire              reset,
  input  wire              strobe_i,
  input  wire set_addr_t   addr_i,
  input  wire set_data_t   data_i,
  output logic [width-1:0] value_o
);

  // Only the low bits of the bus word are kept
  always_ff @(posedge clk) begin
    if (reset) begin
      value_o <= at_reset;
    end else if (strobe_i && (addr_i == my_addr)) begin
      value_o <= data_i[width-1:0];
    end
  end

endmodule

`default_nettype wire

//--- verilog/mult_add_clip.sv
`default_nettype none

module mult_add_clip
  import tx_frontend_pkg::*;
(
  input  wire          clk,
  input  wire          reset,
  input  wire sample_t a_i,
  input  wire coef_t   b_i,
  input  wire sample_t c_i,
  output wide_t        o_o
);

  // Product is Q2.32, the sum gets one guard bit
  localparam int PROD_W    = SAMPLE_W + COEF_W;
  localparam int PROD_FRAC = SAMPLE_FRAC + COEF_FRAC;
  localparam int SUM_W     = PROD_W + 1;
  localparam int DROP      = PROD_FRAC - WIDE_FRAC;
  localparam int TRUNC_W   = SUM_W - DROP;

  logic signed [PROD_W-1:0]  prod_q;
  sample_t                   c_q;
  logic signed [SUM_W-1:0]   c_aligned;
  logic signed [SUM_W-1:0]   sum;
  logic signed [TRUNC_W-1:0] trunc;
  logic [TRUNC_W-WIDE_W:0]   top_bits;
  wide_t                     clipped;

  // Stage 1: multiply, and hold the addend next to its product
  always_ff @(posedge clk) begin
    if (reset) begin
      prod_q <= '0;
      c_q    <= '0;
    end else begin
      prod_q <= a_i * b_i;
      c_q    <= c_i;
    end
  end

  always_comb begin
    // Move c onto the binary point of the product
    c_aligned = SUM_W'(c_q) <<< (PROD_FRAC - SAMPLE_FRAC);
    sum       = SUM_W'(prod_q) + c_aligned;
    // Drop the extra fraction bits to get Q1.23 plus integer growth
    trunc     = sum[SUM_W-1:DROP];
    top_bits  = trunc[TRUNC_W-1:WIDE_W-1];
    if ((top_bits == '0) || (top_bits == '1)) begin
      clipped = trunc[WIDE_W-1:0];
    end else if (trunc[TRUNC_W-1]) begin
      clipped = WIDE_MIN;
    end else begin
      clipped = WIDE_MAX;
    end
  end

  // Stage 2: registered, saturated result
  always_ff @(posedge clk) begin
    if (reset) begin
      o_o <= '0;
    end else begin
      o_o <= clipped;
    end
  end

endmodule

`default_nettype wire

//--- verilog/add2_and_clip_reg.sv
`default_nettype none

module add2_and_clip_reg
  import tx_frontend_pkg::*;
(
  input  wire        clk,
  input  wire        reset,
  input  wire wide_t in1_i,
  input  wire wide_t in2_i,
  input  wire        stb_i,
  output wide_t      sum_o,
  output logic       stb_o
);

  logic signed [WIDE_W:0] sum_full;
  wide_t                  clipped;

  always_comb begin
    sum_full = (WIDE_W+1)'(in1_i) + (WIDE_W+1)'(in2_i);
    // The two top bits differ only on overflow
    case (sum_full[WIDE_W:WIDE_W-1])
      2'b01:   clipped = WIDE_MAX;
      2'b10:   clipped = WIDE_MIN;
      default: clipped = sum_full[WIDE_W-1:0];
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sum_o <= '0;
      stb_o <= 1'b0;
    end else begin
      sum_o <= clipped;
      stb_o <= stb_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/round_sd.sv
`default_nettype none

module round_sd
  import tx_frontend_pkg::*;
(
  input  wire        clk,
  input  wire        reset,
  input  wire wide_t in_i,
  input  wire        stb_i,
  output sample_t    out_o,
  output logic       stb_o
);

  // Fraction left over from the previous sample
  logic [ROUND_BITS-1:0]  err_q;
  logic signed [WIDE_W:0] sum_full;
  wide_t                  clipped;

  always_comb begin
    // Error is unsigned, so zero extend it
    sum_full = (WIDE_W+1)'(in_i) + (WIDE_W+1)'({1'b0, err_q});
    case (sum_full[WIDE_W:WIDE_W-1])
      2'b01:   clipped = WIDE_MAX;
      2'b10:   clipped = WIDE_MIN;
      default: clipped = sum_full[WIDE_W-1:0];
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      err_q <= '0;
      out_o <= '0;
      stb_o <= 1'b0;
    end else begin
      stb_o <= stb_i;
      // Error memory advances only with valid samples
      if (stb_i) begin
        out_o <= clipped[WIDE_W-1:ROUND_BITS];
        err_q <= clipped[ROUND_BITS-1:0];
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/tx_frontend.sv
`default_nettype none

module tx_frontend
  import tx_frontend_pkg::*;
(
  input  wire            clk,
  input  wire            reset,
  input  wire            set_stb_i,
  input  wire set_addr_t set_addr_i,
  input  wire set_data_t set_data_i,
  input  wire            tx_stb_i,
  input  wire sample_t   tx_i_i,
  input  wire sample_t   tx_q_i,
  output logic           dac_stb_o,
  output sample_t        dac_i_o,
  output sample_t        dac_q_o
);

  wide_t     i_dco;
  wide_t     q_dco;
  coef_t     mag_corr;
  coef_t     phase_corr;
  mux_ctrl_t mux_ctrl;

  logic [1:0] tx_stb_dly;
  logic       tx_comp_stb;
  logic       tx_ofs_stb;
  logic       tx_round_stb;
  wide_t      tx_i_comp;
  wide_t      tx_q_comp;
  wide_t      tx_i_ofs;
  wide_t      tx_q_ofs;
  sample_t    tx_i_round;
  sample_t    tx_q_round;

  // One crossbar leg, driven by one nibble of the control
  function automatic sample_t xbar_pick(logic [MUX_SEL_W-1:0] sel,
                                        sample_t i_s, sample_t q_s);
    sample_t res;
    case (sel)
      XBAR_SEL_I: res = i_s;
      XBAR_SEL_Q: res = q_s;
      default:    res = '0;
    endcase
    return res;
  endfunction

  // Settings registers
  setting_reg #(.my_addr(SR_OFFSET_I), .width(WIDE_W)) i_sr_offset_i (
    .clk(clk), .reset(reset), .strobe_i(set_stb_i), .addr_i(set_addr_i),
    .data_i(set_data_i), .value_o(i_dco)
  );

  setting_reg #(.my_addr(SR_OFFSET_Q), .width(WIDE_W)) i_sr_offset_q (
    .clk(clk), .reset(reset), .strobe_i(set_stb_i), .addr_i(set_addr_i),
    .data_i(set_data_i), .value_o(q_dco)
  );

  setting_reg #(.my_addr(SR_MAG_CORR), .width(COEF_W)) i_sr_mag_corr (
    .clk(clk), .reset(reset), .strobe_i(set_stb_i), .addr_i(set_addr_i),
    .data_i(set_data_i), .value_o(mag_corr)
  );

  setting_reg #(.my_addr(SR_PHASE_CORR), .width(COEF_W)) i_sr_phase_corr (
    .clk(clk), .reset(reset), .strobe_i(set_stb_i), .addr_i(set_addr_i),
    .data_i(set_data_i), .value_o(phase_corr)
  );

  setting_reg #(.my_addr(SR_MUX), .width(MUX_W), .at_reset(MUX_RESET)) i_sr_mux (
    .clk(clk), .reset(reset), .strobe_i(set_stb_i), .addr_i(set_addr_i),
    .data_i(set_data_i), .value_o(mux_ctrl)
  );

  // IQ imbalance: I gets a gain term, Q gets a share of I
  mult_add_clip i_mult_i (
    .clk(clk), .reset(reset), .a_i(tx_i_i), .b_i(mag_corr), .c_i(tx_i_i),
    .o_o(tx_i_comp)
  );

  mult_add_clip i_mult_q (
    .clk(clk), .reset(reset), .a_i(tx_i_i), .b_i(phase_corr), .c_i(tx_q_i),
    .o_o(tx_q_comp)
  );

  // Strobe follows the two multiplier stages
  always_ff @(posedge clk) begin
    if (reset) begin
      tx_stb_dly <= '0;
    end else begin
      tx_stb_dly <= {tx_stb_dly[0], tx_stb_i};
    end
  end

  assign tx_comp_stb = tx_stb_dly[1];

  // DC offset
  add2_and_clip_reg i_add_dco_i (
    .clk(clk), .reset(reset), .in1_i(i_dco), .in2_i(tx_i_comp),
    .stb_i(tx_comp_stb), .sum_o(tx_i_ofs), .stb_o(tx_ofs_stb)
  );

  // Q strobe is identical to the I one
  add2_and_clip_reg i_add_dco_q (
    .clk(clk), .reset(reset), .in1_i(q_dco), .in2_i(tx_q_comp),
    .stb_i(tx_comp_stb), .sum_o(tx_q_ofs), .stb_o()
  );

  // Back to 16 bits with noise shaping
  round_sd i_round_i (
    .clk(clk), .reset(reset), .in_i(tx_i_ofs), .stb_i(tx_ofs_stb),
    .out_o(tx_i_round), .stb_o(tx_round_stb)
  );

  round_sd i_round_q (
    .clk(clk), .reset(reset), .in_i(tx_q_ofs), .stb_i(tx_ofs_stb),
    .out_o(tx_q_round), .stb_o()
  );

  // Output crossbar, low nibble feeds DAC I and high nibble DAC Q
  always_ff @(posedge clk) begin
    if (reset) begin
      dac_stb_o <= 1'b0;
      dac_i_o   <= '0;
      dac_q_o   <= '0;
    end else begin
      dac_stb_o <= tx_round_stb;
      dac_i_o   <= xbar_pick(mux_ctrl[MUX_SEL_W-1:0], tx_i_round, tx_q_round);
      dac_q_o   <= xbar_pick(mux_ctrl[MUX_W-1:MUX_SEL_W], tx_i_round, tx_q_round);
    end
  end

endmodule

`default_nettype wire

//--- test/tx_frontend_model.svh
// Reference model of the transmit chain, one function per stage
// Widths follow the formats Q1.15, Q1.17 and Q1.23

// Clamp to the signed 24-bit range
function automatic wide_t sat_wide(longint v);
  if (v > 64'sd8388607) begin
    return 24'h7fffff;
  end
  if (v < -64'sd8388608) begin
    return 24'h800000;
  end
  return wide_t'(v);
endfunction

// a times b is Q2.32, c is moved onto that point, then floor to Q1.23
function automatic wide_t comp_model(sample_t a, coef_t b, sample_t c);
  longint acc;
  acc = longint'(a) * longint'(b) + (longint'(c) <<< 17);
  return sat_wide(acc >>> 9);
endfunction

function automatic wide_t offset_model(wide_t ofs, wide_t x);
  return sat_wide(longint'(ofs) + longint'(x));
endfunction

// Carried fraction is unsigned and only moves with a sample
function automatic sample_t round_model(wide_t x, inout logic [7:0] err);
  wide_t s;
  s   = sat_wide(longint'(x) + longint'(err));
  err = s[7:0];
  return sample_t'(s >>> 8);
endfunction

// Nibble code 0 picks I, 1 picks Q, the rest give silence
function automatic sample_t xbar_model(logic [3:0] sel, sample_t i_s, sample_t q_s);
  case (sel)
    4'd0:    return i_s;
    4'd1:    return q_s;
    default: return '0;
  endcase
endfunction

//--- test/tx_frontend_tb.sv
`default_nettype none

module tx_frontend_tb
  import tx_frontend_pkg::*;
();

  localparam int LATENCY   = 5;
  localparam int N_BASIC   = 16;
  localparam int N_BURST   = 24;
  localparam int N_GAPPED  = 16;
  localparam int N_CORR    = 64;
  localparam int N_OFFSET  = 64;
  localparam int N_XBAR    = 40;
  localparam int N_BADADDR = 16;
  localparam int N_TOTAL   = N_BASIC + N_BURST + N_GAPPED + N_CORR + N_OFFSET + N_XBAR
                             + N_BADADDR;
  localparam mux_ctrl_t XBAR_TAB [5] = '{8'h00, 8'h01, 8'h10, 8'h11, 8'h22};

  logic      clk;
  logic      reset;
  logic      set_stb_i;
  set_addr_t set_addr_i;
  set_data_t set_data_i;
  logic      tx_stb_i;
  sample_t   tx_i_i;
  sample_t   tx_q_i;
  logic      dac_stb_o;
  sample_t   dac_i_o;
  sample_t   dac_q_o;

  // Settings as the model sees them, plus its rounding memory
  wide_t      m_ofs_i;
  wide_t      m_ofs_q;
  coef_t      m_mag;
  coef_t      m_phase;
  mux_ctrl_t  m_mux;
  logic [7:0] m_err_i;
  logic [7:0] m_err_q;

  sample_t exp_i_q[$];
  sample_t exp_q_q[$];
  int      errors;
  int      sent_cnt;
  int      got_cnt;
  int      test_num;
  int      test_err0;
  int      tests_ok;
  int      seed_ret;
  string   test_name;

  `include "tx_frontend_model.svh"

  tx_frontend i_dut (
    .clk(clk), .reset(reset), .set_stb_i(set_stb_i), .set_addr_i(set_addr_i),
    .set_data_i(set_data_i), .tx_stb_i(tx_stb_i), .tx_i_i(tx_i_i), .tx_q_i(tx_q_i),
    .dac_stb_o(dac_stb_o), .dac_i_o(dac_i_o), .dac_q_o(dac_q_o)
  );

  always #50 clk = ~clk;

  // Every input strobe comes out after the full pipeline depth
  stb_latency: assert property (@(posedge clk) disable iff (reset)
    dac_stb_o == $past(tx_stb_i, LATENCY))
    else begin
      errors++;
      $display("Output strobe at %0t does not trail the input strobe by 5 cycles", $time);
    end

  task automatic check_sample(string sig, sample_t got, sample_t exp);
    assert (got == exp) else begin
      errors++;
      $display("Mismatch %s: got %h expected %h at %0t", sig, got, exp, $time);
    end
  endtask

  // Each output strobe retires the oldest sample in flight
  always @(negedge clk) begin
    if (!reset && dac_stb_o) begin
      got_cnt++;
      if (exp_i_q.size() == 0) begin
        errors++;
        $display("Output strobe at %0t with no sample in flight", $time);
      end else begin
        check_sample("dac_i_o", dac_i_o, exp_i_q.pop_front());
        check_sample("dac_q_o", dac_q_o, exp_q_q.pop_front());
      end
    end
  end

  initial begin
    repeat (N_TOTAL * 10 + 1000) @(posedge clk);
    $display("Watchdog expired after %0d cycles, outputs stopped coming", N_TOTAL * 10 + 1000);
    $display("Done: errors found");
    $finish;
  end

  // Data wanders while the strobe is low
  task automatic idle(int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      tx_stb_i = 1'b0;
      tx_i_i   = sample_t'($urandom);
      tx_q_i   = sample_t'($urandom);
    end
  endtask

  task automatic drain();
    idle(1);
    while (exp_i_q.size() != 0) begin
      @(posedge clk);
    end
    idle(2);
  endtask

  task automatic send_sample(sample_t i_s, sample_t q_s);
    wide_t   i_w;
    wide_t   q_w;
    sample_t r_i;
    sample_t r_q;
    @(posedge clk);
    #1;
    tx_stb_i = 1'b1;
    tx_i_i   = i_s;
    tx_q_i   = q_s;
    i_w = offset_model(m_ofs_i, comp_model(i_s, m_mag, i_s));
    q_w = offset_model(m_ofs_q, comp_model(i_s, m_phase, q_s));
    r_i = round_model(i_w, m_err_i);
    r_q = round_model(q_w, m_err_q);
    exp_i_q.push_back(xbar_model(m_mux[3:0], r_i, r_q));
    exp_q_q.push_back(xbar_model(m_mux[7:4], r_i, r_q));
    sent_cnt++;
  endtask

  // Registers take the low bits of the word, other addresses are ignored
  task automatic write_setting(set_addr_t addr, set_data_t data);
    drain();
    @(posedge clk);
    #1;
    set_stb_i  = 1'b1;
    set_addr_i = addr;
    set_data_i = data;
    @(posedge clk);
    #1;
    set_stb_i = 1'b0;
    case (addr)
      8'd0:    m_ofs_i = data[23:0];
      8'd1:    m_ofs_q = data[23:0];
      8'd2:    m_mag = data[17:0];
      8'd3:    m_phase = data[17:0];
      8'd4:    m_mux = data[7:0];
      default: begin
      end
    endcase
  endtask

  task automatic start_test(string name);
    test_num++;
    test_name = name;
    test_err0 = errors;
  endtask

  task automatic end_test();
    drain();
    if (got_cnt != sent_cnt) begin
      errors++;
      $display("Output count %0d differs from input count %0d", got_cnt, sent_cnt);
    end
    if (errors == test_err0) begin
      tests_ok++;
    end
    $display("Test %0d (%s): %s, %0d errors", test_num, test_name,
             (errors == test_err0) ? "passed" : "failed", errors - test_err0);
  endtask

  initial begin
    int k;
    int j;
    seed_ret   = $urandom(32'hedea_3e88);
    clk        = 1'b0;
    reset      = 1'b1;
    set_stb_i  = 1'b0;
    set_addr_i = '0;
    set_data_i = '0;
    tx_stb_i   = 1'b0;
    tx_i_i     = '0;
    tx_q_i     = '0;
    m_ofs_i    = '0;
    m_ofs_q    = '0;
    m_mag      = '0;
    m_phase    = '0;
    m_mux      = 8'h10;
    m_err_i    = '0;
    m_err_q    = '0;
    errors     = 0;
    sent_cnt   = 0;
    got_cnt    = 0;
    test_num   = 0;
    tests_ok   = 0;
    repeat (10) @(posedge clk);
    #1;
    reset = 1'b0;

    start_test("defaults after reset");
    repeat (3) begin
      idle(1);
      @(negedge clk);
      assert (dac_stb_o == 1'b0) else begin
        errors++;
        $display("Output strobe high before any input at %0t", $time);
      end
      check_sample("dac_i_o", dac_i_o, 16'sh0000);
      check_sample("dac_q_o", dac_q_o, 16'sh0000);
    end
    for (j = 0; j < N_BASIC; j++) begin
      send_sample(sample_t'($urandom), sample_t'($urandom));
    end
    end_test();

    start_test("back-to-back and gapped strobes");
    for (k = 0; k < N_BURST / 8; k++) begin
      for (j = 0; j < 8; j++) begin
        send_sample(sample_t'($urandom), sample_t'($urandom));
      end
      idle(2 * k + 1);
    end
    for (j = 0; j < N_GAPPED; j++) begin
      send_sample(sample_t'($urandom), sample_t'($urandom));
      idle($urandom_range(4, 1));
    end
    end_test();

    start_test("IQ correction with noise shaping");
    for (k = 0; k < 4; k++) begin
      write_setting(SR_MAG_CORR, $urandom);
      write_setting(SR_PHASE_CORR, $urandom);
      for (j = 0; j < N_CORR / 4; j++) begin
        send_sample(sample_t'($urandom), sample_t'($urandom));
        if ($urandom_range(3, 0) == 0) begin
          idle(1);
        end
      end
    end
    end_test();

    start_test("DC offset saturation");
    write_setting(SR_MAG_CORR, 32'd0);
    write_setting(SR_PHASE_CORR, 32'd0);
    for (k = 0; k < N_OFFSET / 8; k++) begin
      write_setting(SR_OFFSET_I, (k == 0) ? 32'h007f_ffff : (k == 1) ? 32'h0080_0000 : $urandom);
      write_setting(SR_OFFSET_Q, (k == 0) ? 32'h0080_0000 : (k == 1) ? 32'h007f_ffff : $urandom);
      for (j = 0; j < 8; j++) begin
        case (j % 4)
          0:       send_sample(16'sh7fff, 16'sh8000);
          1:       send_sample(16'sh8000, 16'sh7fff);
          2:       send_sample(16'sh7fff, 16'sh7fff);
          default: send_sample(sample_t'($urandom), sample_t'($urandom));
        endcase
      end
    end
    end_test();

    start_test("crossbar routing");
    write_setting(SR_OFFSET_I, 32'd0);
    write_setting(SR_OFFSET_Q, 32'd0);
    for (k = 0; k < 5; k++) begin
      write_setting(SR_MUX, set_data_t'(XBAR_TAB[k]));
      for (j = 0; j < N_XBAR / 5; j++) begin
        send_sample(sample_t'($urandom), sample_t'($urandom));
      end
    end
    write_setting(SR_MUX, 32'h10);
    end_test();

    start_test("write to unused address");
    write_setting(8'd9, $urandom);
    for (j = 0; j < N_BADADDR; j++) begin
      send_sample(sample_t'($urandom), sample_t'($urandom));
    end
    end_test();

    $display("Tests run: %0d, passed: %0d, failed checks: %0d", test_num, tests_ok, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+test
verilog/tx_frontend_pkg.sv
verilog/setting_reg.sv
verilog/mult_add_clip.sv
verilog/add2_and_clip_reg.sv
verilog/round_sd.sv
verilog/tx_frontend.sv
test/tx_frontend_tb.sv

//--- Makefile
TOP := tx_frontend_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --timing -f build.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "Done: no errors" sim.log

lint:
	verilator --lint-only --assert --timing -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log
